/* all.f */
src/usb_pkg.sv
src/dev_pkg.sv
src/token_decode.sv
src/transaction_exec.sv
src/response_out.sv
src/usb_token_core.sv
bench/tb_usb_token_core.sv

/* bench/tb_usb_token_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_token_core;

  localparam int NUM_PKTS     = 400;
  localparam int RESET_CYCLES = 10;
  localparam int PKT_CYCLES   = 12;  // Above the average of bytes plus gaps
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_PKTS * PKT_CYCLES;
  localparam int LATENCY      = 3;   // Last byte to outputs

  // Expected outcome of one packet
  localparam int R_NONE   = 0;
  localparam int R_BULK   = 1;
  localparam int R_HSK    = 2;
  localparam int R_SOF    = 3;
  localparam int R_PIDERR = 4;
  localparam int R_CRCERR = 5;

  logic                         clock = 1'b0;
  logic                         areset_n;
  logic                         rx_valid_i;
  logic [7:0]                   rx_data_i;
  logic                         rx_last_i;
  logic [usb_pkg::ADDR_W-1:0]   dev_addr_i;
  logic                         blk_in_ready_i;
  logic                         blk_out_ready_i;
  logic                         blk_start_o;
  logic                         blk_dir_in_o;
  logic [usb_pkg::ENDP_W-1:0]   blk_endpt_o;
  logic                         hsk_valid_o;
  usb_pkg::pid_t                hsk_pid_o;
  logic                         sof_o;
  logic [usb_pkg::FRAME_W-1:0]  frame_o;
  logic                         pid_err_o;
  logic                         crc_err_o;
  logic                         err_seen_o;
  logic                         sof_seen_o;

  int          seed = 47;
  int          cyc = 0;        // Counts rising edges
  logic        checking;
  string       cur_test;

  // Packet under construction
  logic [7:0]  pkt_bytes [4];
  int          pkt_len;
  logic        nxt_in_rdy;
  logic        nxt_out_rdy;
  int          exp_res;
  logic [10:0] exp_val;       // Frame, {dir, endp} or handshake PID
  string       exp_name;

  // Results in flight
  int          q_due [$];
  int          q_res [$];
  logic [10:0] q_val [$];
  string       q_name [$];

  // Reference state of the held outputs
  logic [10:0] model_frame;
  logic        model_err_seen;
  logic        model_sof_seen;

  usb_token_core dut (
    .clock          (clock),
    .areset_n       (areset_n),
    .rx_valid_i     (rx_valid_i),
    .rx_data_i      (rx_data_i),
    .rx_last_i      (rx_last_i),
    .dev_addr_i     (dev_addr_i),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .blk_start_o    (blk_start_o),
    .blk_dir_in_o   (blk_dir_in_o),
    .blk_endpt_o    (blk_endpt_o),
    .hsk_valid_o    (hsk_valid_o),
    .hsk_pid_o      (hsk_pid_o),
    .sof_o          (sof_o),
    .frame_o        (frame_o),
    .pid_err_o      (pid_err_o),
    .crc_err_o      (crc_err_o),
    .err_seen_o     (err_seen_o),
    .sof_seen_o     (sof_seen_o)
  );

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $fatal(1, "Stopped on timeout");
    end
  end

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s expected %0h actual %0h", cur_test, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "Stopped on mismatch");
    end
  endtask

  // Reference CRC5 of x^5 + x^2 + 1 taken LSB first from all ones and inverted
  function automatic logic [4:0] crc5_expected(input logic [10:0] bits);
    logic [4:0] c;
    logic       fb;
    int         i;
    c = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb   = c[4] ^ bits[i];
      c[4] = c[3];
      c[3] = c[2];
      c[2] = c[1] ^ fb;
      c[1] = c[0];
      c[0] = fb;
    end
    return ~c;
  endfunction

  function automatic bit is_token_pid(input logic [7:0] b);
    logic [3:0] p;
    p = b[3:0];
    if (b[7:4] != ~p) begin
      return 1'b0;
    end
    return (p == usb_pkg::PID_OUT) || (p == usb_pkg::PID_IN) ||
           (p == usb_pkg::PID_SOF) || (p == usb_pkg::PID_SETUP);
  endfunction

  // Random packet plus its predicted outcome
  task automatic build_packet();
    int          kind;
    int          sel;
    int          flip;
    logic [3:0]  pid;
    logic [6:0]  addr;
    logic [3:0]  endp;
    logic [10:0] low;
    logic [15:0] field;
    logic [7:0]  bad;
    logic        rdy;
    kind        = {$random(seed)} % 7;
    sel         = (kind < 4) ? kind : {$random(seed)} % 4;
    nxt_in_rdy  = $random(seed);
    nxt_out_rdy = $random(seed);
    endp        = {$random(seed)} % 4;
    addr        = $random(seed);
    if ($random(seed) & 1) begin
      addr = dev_addr_i;
    end
    case (sel)
      0:       pid = usb_pkg::PID_IN;
      1:       pid = usb_pkg::PID_OUT;
      2:       pid = usb_pkg::PID_SETUP;
      default: pid = usb_pkg::PID_SOF;
    endcase
    low      = (pid == usb_pkg::PID_SOF) ? $random(seed) : {endp, addr};
    field    = {crc5_expected(low), low};
    bad      = {~pid, pid};
    pkt_len  = 3;
    exp_res  = R_NONE;
    exp_val  = '0;
    exp_name = "other address";
    case (kind)
      4: begin
        while (is_token_pid(bad)) begin
          bad = $random(seed);
        end
        exp_res  = R_PIDERR;
        exp_name = "bad pid";
      end
      5: begin
        pkt_len  = ($random(seed) & 1) ? 4 : 2;
        exp_res  = R_PIDERR;
        exp_name = "bad length";
      end
      6: begin
        flip        = 11 + {$random(seed)} % 5;
        field[flip] = ~field[flip];
        exp_res     = R_CRCERR;
        exp_name    = "bad crc";
      end
      default: begin
        if (pid == usb_pkg::PID_SOF) begin
          exp_res  = R_SOF;       // Any address
          exp_val  = low;
          exp_name = "sof";
        end else if (addr != dev_addr_i) begin
          exp_res = R_NONE;
        end else if (pid == usb_pkg::PID_SETUP || endp != dev_pkg::BULK_ENDP) begin
          exp_res  = R_HSK;
          exp_val  = {7'd0, usb_pkg::PID_STALL};
          exp_name = "stall";
        end else begin
          rdy = (pid == usb_pkg::PID_IN) ? nxt_in_rdy : nxt_out_rdy;
          if (rdy) begin
            exp_res  = R_BULK;
            exp_val  = {6'd0, (pid == usb_pkg::PID_IN), endp};
            exp_name = "bulk";
          end else begin
            exp_res  = R_HSK;
            exp_val  = {7'd0, usb_pkg::PID_NAK};
            exp_name = "nak";
          end
        end
      end
    endcase
    pkt_bytes[0] = bad;
    pkt_bytes[1] = field[7:0];  // LSB first
    pkt_bytes[2] = field[15:8];
    pkt_bytes[3] = $random(seed);
  endtask

  task automatic send_packet(input bit burst);
    int i;
    int gap;
    for (i = 0; i < pkt_len; i++) begin
      @(negedge clock);
      rx_valid_i = 1'b1;
      rx_data_i  = pkt_bytes[i];
      rx_last_i  = (i == pkt_len - 1);
      // Previous packet has sampled the readies by now
      if (i == 1) begin
        blk_in_ready_i  = nxt_in_rdy;
        blk_out_ready_i = nxt_out_rdy;
      end
      if (i == pkt_len - 1 && exp_res != R_NONE) begin
        q_due.push_back(cyc + LATENCY);
        q_res.push_back(exp_res);
        q_val.push_back(exp_val);
        q_name.push_back(exp_name);
      end
      gap = burst ? 0 : {$random(seed)} % 4;
      repeat (gap) begin
        @(negedge clock);
        rx_valid_i = 1'b0;
        rx_last_i  = 1'b0;
      end
    end
  endtask

  // Idle cycles must show no strobe
  always @(negedge clock) begin : check_outputs
    int          res;
    logic [10:0] val;
    if (checking) begin
      res      = R_NONE;
      val      = '0;
      cur_test = "idle";
      if (q_due.size() > 0 && q_due[0] == cyc) begin
        q_due.delete(0);
        res      = q_res.pop_front();
        val      = q_val.pop_front();
        cur_test = q_name.pop_front();
      end
      check_value("blk_start_o", res == R_BULK, blk_start_o);
      check_value("hsk_valid_o", res == R_HSK, hsk_valid_o);
      check_value("sof_o", res == R_SOF, sof_o);
      check_value("pid_err_o", res == R_PIDERR, pid_err_o);
      check_value("crc_err_o", res == R_CRCERR, crc_err_o);
      if (res == R_BULK) begin
        check_value("blk_dir_in_o", val[4], blk_dir_in_o);
        check_value("blk_endpt_o", val[3:0], blk_endpt_o);
      end
      if (res == R_HSK) begin
        check_value("hsk_pid_o", val[3:0], hsk_pid_o);
      end
      if (res == R_SOF) begin
        model_frame    = val;
        model_sof_seen = 1'b1;
      end
      if (res == R_PIDERR || res == R_CRCERR) begin
        model_err_seen = 1'b1;
      end
      check_value("frame_o", model_frame, frame_o);
      check_value("err_seen_o", model_err_seen, err_seen_o);
      check_value("sof_seen_o", model_sof_seen, sof_seen_o);
    end
  end

  initial begin : stimulus
    int p;
    areset_n        = 1'b0;
    rx_valid_i      = 1'b0;
    rx_data_i       = '0;
    rx_last_i       = 1'b0;
    dev_addr_i      = '0;
    blk_in_ready_i  = 1'b0;
    blk_out_ready_i = 1'b0;
    checking        = 1'b0;
    model_frame     = '0;
    model_err_seen  = 1'b0;
    model_sof_seen  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    areset_n   = 1'b1;
    dev_addr_i = $random(seed);
    checking   = 1'b1;
    for (p = 0; p < NUM_PKTS; p++) begin
      build_packet();
      send_packet((p % 8) >= 5);  // Runs of three back to back
    end
    @(negedge clock);
    rx_valid_i = 1'b0;
    rx_last_i  = 1'b0;
    while (q_due.size() > 0) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/dev_pkg.sv */
`default_nettype none

package dev_pkg;

  // Only bulk endpoint this device serves
  localparam logic [usb_pkg::ENDP_W-1:0] BULK_ENDP = 4'd1;

  // Byte counter of the receive side, saturating
  localparam int BYTE_CNT_W = 3;
  localparam logic [BYTE_CNT_W-1:0] TOKEN_BYTES = 3'd3;  // PID plus two field bytes

  // Decision kinds passed from transaction_exec to response_out
  localparam int KIND_W = 2;
  localparam logic [KIND_W-1:0] KIND_BULK = 2'd0;
  localparam logic [KIND_W-1:0] KIND_HSK  = 2'd1;
  localparam logic [KIND_W-1:0] KIND_SOF  = 2'd2;

endpackage

`default_nettype wire

/* src/response_out.sv */
`timescale 1ns/10ps
`default_nettype none

module response_out (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         exec_valid_i,
  input  logic [dev_pkg::KIND_W-1:0]   exec_kind_i,
  input  logic                         exec_dir_in_i,
  input  logic [usb_pkg::ENDP_W-1:0]   exec_endp_i,
  input  usb_pkg::pid_t                exec_hsk_i,
  input  logic [usb_pkg::FRAME_W-1:0]  exec_frame_i,
  input  logic                         pid_err_i,
  input  logic                         crc_err_i,
  output logic                         blk_start_o,
  output logic                         blk_dir_in_o,
  output logic [usb_pkg::ENDP_W-1:0]   blk_endpt_o,
  output logic                         hsk_valid_o,
  output usb_pkg::pid_t                hsk_pid_o,
  output logic                         sof_o,
  output logic [usb_pkg::FRAME_W-1:0]  frame_o,
  output logic                         pid_err_o,
  output logic                         crc_err_o,
  output logic                         err_seen_o,
  output logic                         sof_seen_o
);

  logic bulk_w;
  logic hsk_w;
  logic sof_w;
  logic pid_err_q;  // Error strobes in step with the execute stage
  logic crc_err_q;

  assign bulk_w = exec_valid_i & (exec_kind_i == dev_pkg::KIND_BULK);
  assign hsk_w  = exec_valid_i & (exec_kind_i == dev_pkg::KIND_HSK);
  assign sof_w  = exec_valid_i & (exec_kind_i == dev_pkg::KIND_SOF);

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      blk_start_o <= 1'b0;
      hsk_valid_o <= 1'b0;
      sof_o       <= 1'b0;
      pid_err_q   <= 1'b0;
      crc_err_q   <= 1'b0;
      pid_err_o   <= 1'b0;
      crc_err_o   <= 1'b0;
      frame_o     <= '0;
      err_seen_o  <= 1'b0;
      sof_seen_o  <= 1'b0;
    end else begin
      blk_start_o <= bulk_w;
      hsk_valid_o <= hsk_w;
      sof_o       <= sof_w;
      pid_err_q   <= pid_err_i;
      crc_err_q   <= crc_err_i;
      pid_err_o   <= pid_err_q;
      crc_err_o   <= crc_err_q;
      if (sof_w) begin
        frame_o    <= exec_frame_i;  // Held until next SOF
        sof_seen_o <= 1'b1;
      end
      // Sticky until reset
      if (pid_err_q | crc_err_q) begin
        err_seen_o <= 1'b1;
      end
    end
  end

  // Transfer parameters follow their strobes
  always_ff @(posedge clock) begin
    if (bulk_w) begin
      blk_dir_in_o <= exec_dir_in_i;
      blk_endpt_o  <= exec_endp_i;
    end
    if (hsk_w) begin
      hsk_pid_o <= exec_hsk_i;
    end
  end

endmodule

`default_nettype wire

/* src/token_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module token_decode (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  rx_valid_i,
  input  logic [7:0]            rx_data_i,
  input  logic                  rx_last_i,
  output logic                  pkt_valid_o,
  output usb_pkg::pid_t         pkt_pid_o,
  output usb_pkg::token_field_u pkt_field_o,
  output logic                  pid_err_o,
  output logic                  crc_err_o
);

  logic [dev_pkg::BYTE_CNT_W-1:0] byte_cnt_q;  // Bytes seen so far in this packet
  logic [dev_pkg::BYTE_CNT_W-1:0] byte_num_w;  // Position of current byte, PID is 1
  logic [7:0]                     pid_q;
  logic [7:0]                     lo_q;        // Low byte of the field
  logic [7:0]                     pid_byte_w;
  usb_pkg::token_field_u          field_w;
  logic [usb_pkg::CRC5_W-1:0]     crc_w;
  logic                           done_w;
  logic                           pid_ok_w;
  logic                           len_ok_w;
  logic                           crc_ok_w;

  // Serial CRC5 over the frame bits, LSB first
  function automatic logic [usb_pkg::CRC5_W-1:0] crc5(
    input logic [usb_pkg::FRAME_W-1:0] data
  );
    logic [usb_pkg::CRC5_W-1:0] crc;
    logic                       fb;
    integer                     i;
    crc = usb_pkg::CRC5_INIT;
    for (i = 0; i < usb_pkg::FRAME_W; i = i + 1) begin
      fb  = crc[usb_pkg::CRC5_W-1] ^ data[i];
      crc = {crc[usb_pkg::CRC5_W-2:0], 1'b0};
      if (fb) begin
        crc = crc ^ usb_pkg::CRC5_POLY;
      end
    end
    return ~crc;  // Residue is sent inverted
  endfunction

  assign done_w     = rx_valid_i & rx_last_i;
  assign byte_num_w = byte_cnt_q + 1'b1;

  // A one-byte packet carries its PID on the last strobe
  assign pid_byte_w = (byte_cnt_q == '0) ? rx_data_i : pid_q;

  // High byte is the one arriving now
  assign field_w = {rx_data_i, lo_q};

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      byte_cnt_q <= '0;
    end else if (rx_valid_i) begin
      if (rx_last_i) begin
        byte_cnt_q <= '0;  // Next byte is a PID
      end else if (byte_cnt_q != '1) begin
        byte_cnt_q <= byte_num_w;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_valid_i) begin
      case (byte_cnt_q)
        0:       pid_q <= rx_data_i;
        1:       lo_q  <= rx_data_i;
        default: ;
      endcase
    end
  end

  // Check nibble and token class
  always_comb begin
    case (pid_byte_w[3:0])
      usb_pkg::PID_OUT, usb_pkg::PID_IN, usb_pkg::PID_SOF, usb_pkg::PID_SETUP:
        pid_ok_w = (pid_byte_w[7:4] == ~pid_byte_w[3:0]);
      default:
        pid_ok_w = 1'b0;
    endcase
  end

  assign len_ok_w = (byte_num_w == dev_pkg::TOKEN_BYTES);

  // Token and SOF share the low 11 bits as CRC input
  assign crc_w    = crc5(field_w.sof[usb_pkg::FRAME_W-1:0]);
  assign crc_ok_w = (crc_w == field_w.sof[usb_pkg::CRC5_LSB +: usb_pkg::CRC5_W]);

  // Exactly one strobe per packet
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      pkt_valid_o <= 1'b0;
      pid_err_o   <= 1'b0;
      crc_err_o   <= 1'b0;
    end else begin
      pkt_valid_o <= done_w & pid_ok_w & len_ok_w & crc_ok_w;
      pid_err_o   <= done_w & ~(pid_ok_w & len_ok_w);
      crc_err_o   <= done_w & pid_ok_w & len_ok_w & ~crc_ok_w;
    end
  end

  always_ff @(posedge clock) begin
    if (done_w) begin
      pkt_pid_o   <= pid_byte_w[3:0];
      pkt_field_o <= field_w;
    end
  end

endmodule

`default_nettype wire

/* src/transaction_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module transaction_exec (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         pkt_valid_i,
  input  usb_pkg::pid_t                pkt_pid_i,
  input  usb_pkg::token_field_u        pkt_field_i,
  input  logic [usb_pkg::ADDR_W-1:0]   dev_addr_i,
  input  logic                         blk_in_ready_i,
  input  logic                         blk_out_ready_i,
  output logic                         exec_valid_o,
  output logic [dev_pkg::KIND_W-1:0]   exec_kind_o,
  output logic                         exec_dir_in_o,
  output logic [usb_pkg::ENDP_W-1:0]   exec_endp_o,
  output usb_pkg::pid_t                exec_hsk_o,
  output logic [usb_pkg::FRAME_W-1:0]  exec_frame_o
);

  logic [usb_pkg::ADDR_W-1:0]  tok_addr_w;
  logic [usb_pkg::ENDP_W-1:0]  tok_endp_w;
  logic [usb_pkg::FRAME_W-1:0] sof_frame_w;
  logic                        is_sof_w;
  logic                        addr_hit_w;
  logic                        accept_w;
  logic                        bulk_ep_w;
  logic                        dir_in_w;
  logic                        ready_w;
  logic [dev_pkg::KIND_W-1:0]  kind_w;
  usb_pkg::pid_t               hsk_w;

  // Token view
  assign tok_addr_w = pkt_field_i.tok[usb_pkg::ADDR_W-1:0];
  assign tok_endp_w = pkt_field_i.tok[usb_pkg::ENDP_LSB +: usb_pkg::ENDP_W];

  // SOF view
  assign sof_frame_w = pkt_field_i.sof[usb_pkg::FRAME_W-1:0];

  assign is_sof_w   = (pkt_pid_i == usb_pkg::PID_SOF);
  assign addr_hit_w = (tok_addr_w == dev_addr_i);
  assign accept_w   = pkt_valid_i & (is_sof_w | addr_hit_w);  // SOF ignores address

  assign bulk_ep_w = (tok_endp_w == dev_pkg::BULK_ENDP);
  assign dir_in_w  = (pkt_pid_i == usb_pkg::PID_IN);
  assign ready_w   = dir_in_w ? blk_in_ready_i : blk_out_ready_i;

  // Response decision
  always_comb begin
    kind_w = dev_pkg::KIND_HSK;
    hsk_w  = usb_pkg::PID_STALL;  // SETUP and unknown endpoints
    case (pkt_pid_i)
      usb_pkg::PID_SOF: begin
        kind_w = dev_pkg::KIND_SOF;
      end
      usb_pkg::PID_IN, usb_pkg::PID_OUT: begin
        if (bulk_ep_w) begin
          if (ready_w) begin
            kind_w = dev_pkg::KIND_BULK;
          end else begin
            hsk_w = usb_pkg::PID_NAK;  // Endpoint busy
          end
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      exec_valid_o <= 1'b0;
    end else begin
      exec_valid_o <= accept_w;
    end
  end

  always_ff @(posedge clock) begin
    if (accept_w) begin
      exec_kind_o   <= kind_w;
      exec_dir_in_o <= dir_in_w;
      exec_endp_o   <= tok_endp_w;
      exec_hsk_o    <= hsk_w;
      exec_frame_o  <= sof_frame_w;
    end
  end

endmodule

`default_nettype wire

/* src/usb_pkg.sv */
`default_nettype none

package usb_pkg;

  // Field widths
  localparam int ADDR_W  = 7;
  localparam int ENDP_W  = 4;
  localparam int FRAME_W = 11;
  localparam int CRC5_W  = 5;
  localparam int FIELD_W = 16;  // Two bytes following the PID

  // Bit offsets inside the 16-bit field
  localparam int ENDP_LSB = ADDR_W;
  localparam int CRC5_LSB = FRAME_W;  // CRC5 sits on top in both views

  typedef logic [3:0] pid_t;

  // Token PIDs
  localparam pid_t PID_OUT   = 4'b0001;
  localparam pid_t PID_IN    = 4'b1001;
  localparam pid_t PID_SOF   = 4'b0101;
  localparam pid_t PID_SETUP = 4'b1101;

  // Handshake PIDs
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_STALL = 4'b1110;

  // CRC5 generator x^5 + x^2 + 1, top term implied
  localparam logic [CRC5_W-1:0] CRC5_POLY = 5'b00101;
  localparam logic [CRC5_W-1:0] CRC5_INIT = 5'b11111;  // Shift register preset

  // Field after the PID of token and SOF packets
  // Token view
  //   [6:0]   device address
  //   [10:7]  endpoint
  //   [15:11] CRC5
  // SOF view
  //   [10:0]  frame number
  //   [15:11] CRC5
  typedef union packed {
    logic [FIELD_W-1:0] tok;
    logic [FIELD_W-1:0] sof;
  } token_field_u;

endpackage

`default_nettype wire

/* src/usb_token_core.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_token_core (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         rx_valid_i,
  input  logic [7:0]                   rx_data_i,
  input  logic                         rx_last_i,
  input  logic [usb_pkg::ADDR_W-1:0]   dev_addr_i,
  input  logic                         blk_in_ready_i,
  input  logic                         blk_out_ready_i,
  output logic                         blk_start_o,
  output logic                         blk_dir_in_o,
  output logic [usb_pkg::ENDP_W-1:0]   blk_endpt_o,
  output logic                         hsk_valid_o,
  output usb_pkg::pid_t                hsk_pid_o,
  output logic                         sof_o,
  output logic [usb_pkg::FRAME_W-1:0]  frame_o,
  output logic                         pid_err_o,
  output logic                         crc_err_o,
  output logic                         err_seen_o,
  output logic                         sof_seen_o
);

  // Decode to execute
  logic                        pkt_valid;
  usb_pkg::pid_t               pkt_pid;
  usb_pkg::token_field_u       pkt_field;
  logic                        pid_err;
  logic                        crc_err;

  // Execute to response
  logic                        exec_valid;
  logic [dev_pkg::KIND_W-1:0]  exec_kind;
  logic                        exec_dir_in;
  logic [usb_pkg::ENDP_W-1:0]  exec_endp;
  usb_pkg::pid_t               exec_hsk;
  logic [usb_pkg::FRAME_W-1:0] exec_frame;

  token_decode u_decode (
    .clock      (clock),
    .areset_n   (areset_n),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .rx_last_i  (rx_last_i),
    .pkt_valid_o(pkt_valid),
    .pkt_pid_o  (pkt_pid),
    .pkt_field_o(pkt_field),
    .pid_err_o  (pid_err),
    .crc_err_o  (crc_err)
  );

  transaction_exec u_exec (
    .clock          (clock),
    .areset_n       (areset_n),
    .pkt_valid_i    (pkt_valid),
    .pkt_pid_i      (pkt_pid),
    .pkt_field_i    (pkt_field),
    .dev_addr_i     (dev_addr_i),
    .blk_in_ready_i (blk_in_ready_i),
    .blk_out_ready_i(blk_out_ready_i),
    .exec_valid_o   (exec_valid),
    .exec_kind_o    (exec_kind),
    .exec_dir_in_o  (exec_dir_in),
    .exec_endp_o    (exec_endp),
    .exec_hsk_o     (exec_hsk),
    .exec_frame_o   (exec_frame)
  );

  // Error strobes skip the execute stage
  response_out u_resp (
    .clock        (clock),
    .areset_n     (areset_n),
    .exec_valid_i (exec_valid),
    .exec_kind_i  (exec_kind),
    .exec_dir_in_i(exec_dir_in),
    .exec_endp_i  (exec_endp),
    .exec_hsk_i   (exec_hsk),
    .exec_frame_i (exec_frame),
    .pid_err_i    (pid_err),
    .crc_err_i    (crc_err),
    .blk_start_o  (blk_start_o),
    .blk_dir_in_o (blk_dir_in_o),
    .blk_endpt_o  (blk_endpt_o),
    .hsk_valid_o  (hsk_valid_o),
    .hsk_pid_o    (hsk_pid_o),
    .sof_o        (sof_o),
    .frame_o      (frame_o),
    .pid_err_o    (pid_err_o),
    .crc_err_o    (crc_err_o),
    .err_seen_o   (err_seen_o),
    .sof_seen_o   (sof_seen_o)
  );

endmodule

`default_nettype wire
